//--- verilog.f
uart_pkg.sv
baud_tick_gen.sv
uart_receiver.sv
uart_transmitter.sv
rx_fifo.sv
uart_core.sv
uart_core_props.sv
uart_core_tb.sv

//--- uart_core_tb.sv
`timescale 1ns/100ps

module uart_core_tb;

   import uart_pkg::*;

   localparam int CLKS_PER_TICK = 4;
   localparam int FIFO_DEPTH    = 4;
   localparam int BIT_CLKS      = CLKS_PER_TICK * OVERSAMPLE; // 64 clocks per bit
   localparam int FRAME_CLKS    = BIT_CLKS * (DATA_W + 2);

   logic              clk         = 1'b0;
   logic              rst         = 1'b0; // Active low, held at start
   logic              rx_line     = 1'b1;
   logic              loopback    = 1'b0;
   logic              rx_en       = 1'b1;
   logic              rx_pop      = 1'b0;
   logic              tx_start    = 1'b0;
   logic [DATA_W-1:0] tx_data     = '0;
   logic              tx;
   logic              tx_busy;
   logic              rx_valid;
   logic              rx_overflow;
   logic [DATA_W-1:0] rx_data;
   int                errors      = 0;
   int                errors_seen = 0;
   int                checks      = 0;
   int                tests       = 0;

   uart_core #(
      .CLKS_PER_TICK(CLKS_PER_TICK),
      .FIFO_DEPTH   (FIFO_DEPTH)
   ) dut (
      .clk_i        (clk),
      .rst_i        (rst),
      .rx_i         (loopback ? tx : rx_line), // Loopback mux
      .rx_en_i      (rx_en),
      .rx_pop_i     (rx_pop),
      .tx_start_i   (tx_start),
      .tx_data_i    (tx_data),
      .tx_o         (tx),
      .tx_busy_o    (tx_busy),
      .rx_valid_o   (rx_valid),
      .rx_overflow_o(rx_overflow),
      .rx_data_o    (rx_data)
   );

   always #4 clk = ~clk;

   // Lands 1 ns past the edge
   task automatic step(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAIL %0t ns: %s, expected %0h, got %0h", $time, what, expected, actual);
      end
   endtask

   task automatic finish_test(input string name);
      tests++;
      $display("%-9s %0d errors", name, errors - errors_seen);
      errors_seen = errors;
   endtask

   // Head byte is compared, then popped
   task automatic expect_byte(input string what, input logic [DATA_W-1:0] expected,
                              input int limit);
      int n;
      n = 0;
      while (!rx_valid && n < limit) begin
         step(1);
         n++;
      end
      if (!rx_valid) begin
         errors++;
         $display("Timed out after %0d clocks waiting for rx_valid_o (%s)", limit, what);
      end else begin
         check_value(what, expected, rx_data);
         rx_pop = 1'b1;
         step(1);
         rx_pop = 1'b0;
      end
   endtask

   task automatic wait_idle(input int limit);
      int n;
      n = 0;
      while (tx_busy && n < limit) begin
         step(1);
         n++;
      end
      if (tx_busy) begin
         errors++;
         $display("Timed out after %0d clocks waiting for tx_busy_o to fall", limit);
      end
   endtask

   task automatic send_serial(input logic [DATA_W-1:0] data);
      logic [DATA_W+1:0] frame;
      frame = {1'b1, data, 1'b0}; // Stop, data, start
      for (int i = 0; i < DATA_W + 2; i++) begin
         rx_line = frame[i]; // LSB first
         step(BIT_CLKS);
      end
   endtask

   task automatic recv_serial(output logic [DATA_W-1:0] data, output bit ok);
      int n;
      n = 0;
      while (tx && n < 2 * FRAME_CLKS) begin
         step(1);
         n++;
      end
      ok = !tx;
      if (!ok) begin
         errors++;
         $display("Timed out after %0d clocks waiting for a start bit on tx_o", n);
      end else begin
         step(BIT_CLKS / 2); // Middle of start bit
         check_value("tx_o start bit", 0, tx);
         for (int i = 0; i < DATA_W; i++) begin
            step(BIT_CLKS);
            data[i] = tx;
         end
         step(BIT_CLKS);
         check_value("tx_o stop bit", 1, tx);
      end
   endtask

   // No byte arrives and tx_o stays idle
   task automatic watch_quiet(input string what, input int clks);
      bit seen;
      seen = 1'b0;
      for (int n = 0; n < clks; n++) begin
         step(1);
         seen = seen | rx_valid | !tx;
      end
      check_value(what, 0, seen);
   endtask

   task automatic test_reset();
      check_value("tx_o after reset", 1, tx);
      check_value("tx_busy_o after reset", 0, tx_busy);
      check_value("rx_valid_o after reset", 0, rx_valid);
      check_value("rx_overflow_o after reset", 0, rx_overflow);
      finish_test("reset");
   endtask

   task automatic test_receive();
      logic [DATA_W-1:0] data;
      for (int i = 0; i < 3; i++) begin
         data = DATA_W'($urandom);
         send_serial(data);
         expect_byte("rx_data_o", data, FRAME_CLKS);
      end
      finish_test("receive");
   endtask

   task automatic test_transmit();
      logic [DATA_W-1:0] data;
      logic [DATA_W-1:0] got;
      bit                ok;
      data     = DATA_W'($urandom);
      tx_data  = data;
      tx_start = 1'b1;
      step(1);
      tx_start = 1'b0;
      check_value("tx_busy_o after start", 1, tx_busy);
      recv_serial(got, ok);
      if (ok) begin
         check_value("tx_o frame byte", data, got);
      end
      check_value("tx_busy_o in stop bit", 1, tx_busy);
      tx_data  = ~data;
      tx_start = 1'b1; // Still busy, dropped
      step(1);
      tx_start = 1'b0;
      wait_idle(BIT_CLKS);
      watch_quiet("second frame on tx_o", FRAME_CLKS);
      finish_test("transmit");
   endtask

   task automatic test_glitch_enable();
      // Two short pulses, together a full start count
      for (int i = 0; i < 2; i++) begin
         rx_line = 1'b0;
         step(CLKS_PER_TICK * START_TICKS / 2); // Half the low ticks a start needs
         rx_line = 1'b1;
         step(BIT_CLKS);
      end
      watch_quiet("rx_valid_o after glitch", 2 * FRAME_CLKS);
      rx_en = 1'b0;
      send_serial(DATA_W'($urandom));
      watch_quiet("rx_valid_o with receiver disabled", 2 * FRAME_CLKS);
      rx_en = 1'b1;
      finish_test("glitch");
   endtask

   task automatic test_overflow();
      logic [DATA_W-1:0] sent [FIFO_DEPTH+1];
      for (int i = 0; i <= FIFO_DEPTH; i++) begin
         sent[i] = DATA_W'($urandom);
         send_serial(sent[i]);
         if (i == FIFO_DEPTH - 1) begin
            check_value("rx_overflow_o with FIFO full", 0, rx_overflow);
         end
      end
      // Last done lands in the stop bit of the last frame
      check_value("rx_overflow_o after extra byte", 1, rx_overflow);
      for (int i = 0; i < FIFO_DEPTH; i++) begin
         expect_byte("rx_data_o after overflow", sent[i], 2);
      end
      check_value("rx_valid_o after drain", 0, rx_valid);
      check_value("rx_overflow_o after drain", 1, rx_overflow);
      finish_test("overflow");
   endtask

   task automatic test_loopback();
      logic [DATA_W-1:0] data;
      loopback = 1'b1;
      for (int i = 0; i < 5; i++) begin
         data     = DATA_W'($urandom);
         tx_data  = data;
         tx_start = 1'b1;
         step(1);
         tx_start = 1'b0;
         expect_byte("loopback rx_data_o", data, 2 * FRAME_CLKS);
         wait_idle(FRAME_CLKS);
      end
      loopback = 1'b0;
      finish_test("loopback");
   endtask

   initial begin
      int unsigned seed;
      seed = $urandom(32'he501_6824);
      step(10);
      rst = 1'b1;
      test_reset();
      test_receive();
      test_transmit();
      test_glitch_enable();
      test_overflow();
      test_loopback();
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

//--- uart_core_props.sv
`timescale 1ns/100ps

module uart_core_props (
   input logic clk_i,
   input logic rst_i,
   input logic tx_i,
   input logic tx_busy_i,
   input logic rx_done_i,
   input logic rx_valid_i
);

   // Idle transmitter keeps the line high
   idle_line_high: assert property (@(posedge clk_i) disable iff (!rst_i)
      !tx_busy_i |-> tx_i)
      else $error("tx_o low while the transmitter is idle");

   done_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_i)
      rx_done_i |=> !rx_done_i)
      else $error("receiver done held for two cycles");

   // FIFO only fills from a receiver write
   valid_after_done: assert property (@(posedge clk_i) disable iff (!rst_i)
      $rose(rx_valid_i) |-> $past(rx_done_i))
      else $error("rx_valid_o rose without a preceding done");

endmodule

bind uart_core uart_core_props u_props (
   .clk_i     (clk_i),
   .rst_i     (rst_i),
   .tx_i      (tx_o),
   .tx_busy_i (tx_busy_o),
   .rx_done_i (rx_done),
   .rx_valid_i(rx_valid_o)
);

//--- uart_core.sv
`timescale 1ns/100ps

module uart_core #(
   parameter int CLKS_PER_TICK = 54,
   parameter int FIFO_DEPTH    = 8
) (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        rx_i,
   input  logic                        rx_en_i,
   input  logic                        rx_pop_i,
   input  logic                        tx_start_i,
   input  logic [uart_pkg::DATA_W-1:0] tx_data_i,
   output logic                        tx_o,
   output logic                        tx_busy_o,
   output logic                        rx_valid_o,
   output logic                        rx_overflow_o,
   output logic [uart_pkg::DATA_W-1:0] rx_data_o
);

   import uart_pkg::*;

   logic              tick;    // 1/16 bit enable
   logic [DATA_W-1:0] rx_byte;
   logic              rx_done;

   baud_tick_gen #(
      .CLKS_PER_TICK(CLKS_PER_TICK)
   ) u_tick (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .tick_o(tick)
   );

   uart_receiver u_rx (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .tick_i (tick),
      .rx_en_i(rx_en_i),
      .rx_i   (rx_i),
      .byte_o (rx_byte),
      .done_o (rx_done)
   );

   rx_fifo #(
      .FIFO_DEPTH(FIFO_DEPTH)
   ) u_fifo (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .wr_i      (rx_done),
      .wr_data_i (rx_byte),
      .pop_i     (rx_pop_i),
      .rd_data_o (rx_data_o),
      .valid_o   (rx_valid_o),
      .overflow_o(rx_overflow_o)
   );

   uart_transmitter u_tx (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .tick_i (tick),
      .start_i(tx_start_i),
      .data_i (tx_data_i),
      .tx_o   (tx_o),
      .busy_o (tx_busy_o)
   );

endmodule

//--- rx_fifo.sv
`timescale 1ns/100ps

module rx_fifo #(
   parameter int FIFO_DEPTH = 8
) (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        wr_i,
   input  logic [uart_pkg::DATA_W-1:0] wr_data_i,
   input  logic                        pop_i,
   output logic [uart_pkg::DATA_W-1:0] rd_data_o,
   output logic                        valid_o,
   output logic                        overflow_o
);

   import uart_pkg::*;

   localparam int PTR_W = $clog2(FIFO_DEPTH);
   localparam logic [PTR_W:0] DEPTH_CNT = (PTR_W + 1)'(FIFO_DEPTH);

   logic [DATA_W-1:0] mem [FIFO_DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [PTR_W:0]    count;
   logic              full;
   logic              do_pop;
   logic              do_wr;

   assign full      = (count == DEPTH_CNT);
   assign valid_o   = (count != '0);
   assign do_pop    = pop_i && valid_o; // Pop on empty is ignored
   assign do_wr     = wr_i && (!full || do_pop);
   assign rd_data_o = mem[rd_ptr]; // Head shows without a pop

   always_ff @(posedge clk_i) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         overflow_o <= 1'b0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1; // Wraps, depth is a power of two
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         if (wr_i && !do_wr) begin
            overflow_o <= 1'b1; // Sticky until reset
         end
      end
   end

endmodule

//--- uart_transmitter.sv
`timescale 1ns/100ps

module uart_transmitter (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        tick_i,
   input  logic                        start_i,
   input  logic [uart_pkg::DATA_W-1:0] data_i,
   output logic                        tx_o,
   output logic                        busy_o
);

   import uart_pkg::*;

   localparam logic [TICK_CNT_W-1:0] BIT_LAST  = TICK_CNT_W'(OVERSAMPLE - 1);
   localparam logic [BIT_CNT_W-1:0]  DATA_LAST = BIT_CNT_W'(DATA_W - 1);

   tx_state_e             state;
   tx_state_e             state_next;
   logic [TICK_CNT_W-1:0] tick_cnt;
   logic [TICK_CNT_W-1:0] tick_cnt_next;
   logic [BIT_CNT_W-1:0]  bit_cnt;
   logic [BIT_CNT_W-1:0]  bit_cnt_next;
   logic [DATA_W-1:0]     shift;
   logic [DATA_W-1:0]     shift_next;
   logic                  tx_next;

   assign busy_o = (state != TX_IDLE);

   always_comb begin
      state_next    = state;
      tick_cnt_next = tick_cnt;
      bit_cnt_next  = bit_cnt;
      shift_next    = shift;
      tx_next       = tx_o;
      case (state)
         TX_IDLE: begin
            if (start_i) begin
               state_next    = TX_START;
               tick_cnt_next = '0;
               shift_next    = data_i;
            end
         end
         TX_START: begin
            if (tick_i) begin
               if (tx_o) begin
                  tx_next = 1'b0; // First tick opens the start bit
               end else if (tick_cnt == BIT_LAST) begin
                  state_next    = TX_DATA;
                  tick_cnt_next = '0;
                  bit_cnt_next  = '0;
                  tx_next       = shift[0];
                  shift_next    = {1'b0, shift[DATA_W-1:1]};
               end else begin
                  tick_cnt_next = tick_cnt + 1'b1;
               end
            end
         end
         TX_DATA: begin
            if (tick_i) begin
               if (tick_cnt == BIT_LAST) begin
                  tick_cnt_next = '0;
                  if (bit_cnt == DATA_LAST) begin
                     state_next = TX_STOP;
                     tx_next    = 1'b1;
                  end else begin
                     bit_cnt_next = bit_cnt + 1'b1;
                     tx_next      = shift[0];
                     shift_next   = {1'b0, shift[DATA_W-1:1]};
                  end
               end else begin
                  tick_cnt_next = tick_cnt + 1'b1;
               end
            end
         end
         TX_STOP: begin
            if (tick_i) begin
               if (tick_cnt == BIT_LAST) begin
                  state_next    = TX_IDLE;
                  tick_cnt_next = '0;
               end else begin
                  tick_cnt_next = tick_cnt + 1'b1;
               end
            end
         end
         default: begin
            state_next = TX_IDLE;
            tx_next    = 1'b1;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         state    <= TX_IDLE;
         tick_cnt <= '0;
         bit_cnt  <= '0;
         tx_o     <= 1'b1; // Line idles high
      end else begin
         state    <= state_next;
         tick_cnt <= tick_cnt_next;
         bit_cnt  <= bit_cnt_next;
         tx_o     <= tx_next;
      end
   end

   always_ff @(posedge clk_i) begin
      shift <= shift_next;
   end

endmodule

//--- uart_receiver.sv
`timescale 1ns/100ps

module uart_receiver (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        tick_i,
   input  logic                        rx_en_i,
   input  logic                        rx_i,
   output logic [uart_pkg::DATA_W-1:0] byte_o,
   output logic                        done_o
);

   import uart_pkg::*;

   localparam logic [TICK_CNT_W-1:0] START_LAST = TICK_CNT_W'(START_TICKS - 1);
   localparam logic [TICK_CNT_W-1:0] BIT_LAST   = TICK_CNT_W'(OVERSAMPLE - 1);
   localparam logic [BIT_CNT_W-1:0]  DATA_LAST  = BIT_CNT_W'(DATA_W - 1);

   rx_state_e             state;
   rx_state_e             state_next;
   logic [TICK_CNT_W-1:0] tick_cnt;
   logic [TICK_CNT_W-1:0] tick_cnt_next;
   logic [BIT_CNT_W-1:0]  bit_cnt;
   logic [BIT_CNT_W-1:0]  bit_cnt_next;
   logic [DATA_W-1:0]     shift;
   logic [DATA_W-1:0]     shift_next;
   logic [DATA_W-1:0]     byte_next;
   logic                  done_next;

   always_comb begin
      state_next    = state;
      tick_cnt_next = tick_cnt;
      bit_cnt_next  = bit_cnt;
      shift_next    = shift;
      byte_next     = byte_o;
      done_next     = 1'b0; // Pulse only
      if (rx_en_i && tick_i) begin
         case (state)
            RX_IDLE: begin
               if (rx_i) begin
                  tick_cnt_next = '0; // Line back high, restart count
               end else if (tick_cnt == START_LAST) begin
                  state_next    = RX_DATA; // Now at mid start bit
                  tick_cnt_next = '0;
               end else begin
                  tick_cnt_next = tick_cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (tick_cnt == BIT_LAST) begin
                  tick_cnt_next = '0;
                  shift_next    = {rx_i, shift[DATA_W-1:1]}; // LSB arrives first
                  bit_cnt_next  = bit_cnt + 1'b1;
                  if (bit_cnt == DATA_LAST) begin
                     state_next   = RX_STOP;
                     bit_cnt_next = '0;
                  end
               end else begin
                  tick_cnt_next = tick_cnt + 1'b1;
               end
            end
            RX_STOP: begin
               // Stop level is not checked
               if (tick_cnt == BIT_LAST) begin
                  tick_cnt_next = '0;
                  byte_next     = shift;
                  done_next     = 1'b1;
                  state_next    = RX_IDLE;
               end else begin
                  tick_cnt_next = tick_cnt + 1'b1;
               end
            end
            default: begin
               state_next    = RX_IDLE;
               tick_cnt_next = '0;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         state    <= RX_IDLE;
         tick_cnt <= '0;
         bit_cnt  <= '0;
         done_o   <= 1'b0;
      end else begin
         state    <= state_next;
         tick_cnt <= tick_cnt_next;
         bit_cnt  <= bit_cnt_next;
         done_o   <= done_next;
      end
   end

   always_ff @(posedge clk_i) begin
      shift  <= shift_next;
      byte_o <= byte_next; // Held until next frame
   end

endmodule

//--- baud_tick_gen.sv
`timescale 1ns/100ps

module baud_tick_gen #(
   parameter int CLKS_PER_TICK = 54
) (
   input  logic clk_i,
   input  logic rst_i,
   output logic tick_o
);

   localparam int CNT_W = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;
   localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS_PER_TICK - 1);

   logic [CNT_W-1:0] cnt;
   logic             wrap;

   assign wrap = (cnt == LAST);

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         cnt    <= '0;
         tick_o <= 1'b0;
      end else begin
         if (wrap) begin
            cnt <= '0;
         end else begin
            cnt <= cnt + 1'b1;
         end
         tick_o <= wrap; // One clock wide
      end
   end

endmodule

//--- uart_pkg.sv
package uart_pkg;

   // Character format
   localparam int DATA_W = 8;

   // Ticks per bit period
   localparam int OVERSAMPLE = 16;

   // Half a bit of low line before the start bit counts
   localparam int START_TICKS = 8;

   localparam int TICK_CNT_W = $clog2(OVERSAMPLE);
   localparam int BIT_CNT_W  = $clog2(DATA_W);

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_DATA,
      RX_STOP
   } rx_state_e;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_e;

endpackage
